// File: include/decode_params.svh
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// Word widths
`define DEC_INSN_WIDTH     32
`define DEC_OPERAND_WIDTH  32

// Register file
`define DEC_RF_ADDR_WIDTH  5
`define DEC_LINK_REG       9

// Features present in this core
`define DEC_HAS_MUL        1
`define DEC_HAS_SRA        1
`define DEC_HAS_SYSCALL    1
`define DEC_HAS_TRAP       1
`define DEC_HAS_MSYNC      1

// Features left out, their opcodes decode as illegal
`define DEC_HAS_DIV        0
`define DEC_HAS_ROR        0
`define DEC_HAS_ADDC       0

`endif

// File: design/decode_pkg.sv
`include "decode_params.svh"

package decode_pkg;

   // Major opcodes, instruction bits 31:26
   typedef enum logic [5:0] {
      OPC_J           = 6'h00,
      OPC_JAL         = 6'h01,
      OPC_BNF         = 6'h03,
      OPC_BF          = 6'h04,
      OPC_NOP         = 6'h05,
      OPC_MOVHI       = 6'h06,
      OPC_SYSTRAPSYNC = 6'h08,
      OPC_RFE         = 6'h09,
      OPC_JR          = 6'h11,
      OPC_JALR        = 6'h12,
      OPC_LWZ         = 6'h21,
      OPC_LWS         = 6'h22,
      OPC_LBZ         = 6'h23,
      OPC_LBS         = 6'h24,
      OPC_LHZ         = 6'h25,
      OPC_LHS         = 6'h26,
      OPC_ADDI        = 6'h27,
      OPC_ADDIC       = 6'h28,
      OPC_ANDI        = 6'h29,
      OPC_ORI         = 6'h2A,
      OPC_XORI        = 6'h2B,
      OPC_MULI        = 6'h2C,
      OPC_MFSPR       = 6'h2D,
      OPC_SHRTI       = 6'h2E,
      OPC_SFIMM       = 6'h2F,
      OPC_MTSPR       = 6'h30,
      OPC_SW          = 6'h35,
      OPC_SB          = 6'h36,
      OPC_SH          = 6'h37,
      OPC_ALU         = 6'h38,
      OPC_SF          = 6'h39
   } opcode_e;

   // ALU function, bits 3:0 of register-register ops
   typedef enum logic [3:0] {
      ALU_ADD   = 4'h0,
      ALU_ADDC  = 4'h1,
      ALU_SUB   = 4'h2,
      ALU_AND   = 4'h3,
      ALU_OR    = 4'h4,
      ALU_XOR   = 4'h5,
      ALU_MUL   = 4'h6,
      ALU_SHRT  = 4'h8,
      ALU_DIV   = 4'h9,
      ALU_DIVU  = 4'hA,
      ALU_MULU  = 4'hB,
      ALU_EXTBH = 4'hC,
      ALU_CMOV  = 4'hE,
      ALU_FFL1  = 4'hF
   } alu_opc_e;

   // Shift kind from the secondary field
   typedef enum logic [3:0] {
      SHIFT_SLL = 4'h0,
      SHIFT_SRL = 4'h1,
      SHIFT_SRA = 4'h2,
      SHIFT_ROR = 4'h3
   } shift_opc_e;

   typedef struct packed {
      opcode_e                        opcode;
      logic [`DEC_RF_ADDR_WIDTH-1:0]  rd;
      logic [`DEC_RF_ADDR_WIDTH-1:0]  ra;
      logic [`DEC_RF_ADDR_WIDTH-1:0]  rb;
      logic [15:0]                    imm16;
      logic [9:0]                     jbr_upper;
      alu_opc_e                       alu_opc;
      shift_opc_e                     secondary;
      logic [4:0]                     comp_opc;
      logic [9:0]                     sys_subop;
   } insn_fields_t;

   typedef struct packed {
      logic       jbr;
      logic       jr;
      logic       jal;
      logic       bf;
      logic       bnf;
      logic       brcond;
      logic       branch;
      logic       alu;
      logic       load;
      logic       store;
      logic [1:0] lsu_length;
      logic       lsu_zext;
      logic       mfspr;
      logic       mtspr;
      logic       rfe;
      logic       setflag;
      logic       add;
      logic       mul_signed;
      logic       mul_unsigned;
      logic       shift;
      logic       movhi;
      logic       rf_wb;
      logic       adder_do_sub;
   } op_class_t;

   typedef struct packed {
      logic [`DEC_RF_ADDR_WIDTH-1:0]  rfa;
      logic [`DEC_RF_ADDR_WIDTH-1:0]  rfb;
      logic [`DEC_RF_ADDR_WIDTH-1:0]  rfd;
      logic [15:0]                    imm16;
      logic [`DEC_OPERAND_WIDTH-1:0]  immediate;
      logic                           immediate_sel;
      logic [9:0]                     immjbr_upper;
      alu_opc_e                       opc_alu;
      logic [4:0]                     opc_alu_secondary;
   } operand_t;

   typedef struct packed {
      logic illegal;
      logic syscall;
      logic trap;
      logic msync;
   } except_t;

   // Record handed to the execute stage
   typedef struct packed {
      opcode_e   opcode;
      op_class_t op_class;
      operand_t  operand;
      except_t   except;
   } decode_out_t;

endpackage

// File: design/insn_capture.sv
`include "decode_params.svh"

module insn_capture (
   input  logic                         clk,
   input  logic                         rst_i,
   input  logic                         insn_valid_i,
   input  logic [`DEC_INSN_WIDTH-1:0]   insn_i,
   output decode_pkg::insn_fields_t     fields_o,
   output logic                         fields_valid_o
);
   import decode_pkg::*;

   logic         split_imm;
   insn_fields_t fields_next;

   // Stores and mtspr carry the immediate in two pieces
   assign split_imm = (insn_i[31:26] == OPC_SW) || (insn_i[31:26] == OPC_SB) ||
                      (insn_i[31:26] == OPC_SH) || (insn_i[31:26] == OPC_MTSPR);

   always_comb begin
      fields_next.opcode    = opcode_e'(insn_i[31:26]);
      fields_next.rd        = insn_i[25:21];
      fields_next.ra        = insn_i[20:16];
      fields_next.rb        = insn_i[15:11];
      fields_next.imm16     = split_imm ? {insn_i[25:21], insn_i[10:0]} : insn_i[15:0];
      fields_next.jbr_upper = insn_i[25:16];
      fields_next.alu_opc   = alu_opc_e'(insn_i[3:0]);
      fields_next.secondary = shift_opc_e'(insn_i[9:6]);
      fields_next.comp_opc  = insn_i[25:21];
      fields_next.sys_subop = insn_i[25:16];
   end

   // Field record only changes on a strobe
   always_ff @(posedge clk) begin
      if (insn_valid_i) begin
         fields_o <= fields_next;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         fields_valid_o <= 1'b0;
      end else begin
         fields_valid_o <= insn_valid_i;
      end
   end

endmodule

// File: design/op_class_decode.sv
module op_class_decode (
   input  decode_pkg::insn_fields_t fields_i,
   output decode_pkg::op_class_t    class_o
);
   import decode_pkg::*;

   logic [5:0] opc;
   logic       alu_rr;

   assign opc    = fields_i.opcode;
   assign alu_rr = (opc == OPC_ALU);

   always_comb begin
      class_o = '0;

      // Jumps and branches, the bottom four opcodes take an immediate
      class_o.jbr    = (opc < OPC_NOP);
      class_o.jr     = (opc == OPC_JR) || (opc == OPC_JALR);
      class_o.jal    = (opc == OPC_JAL) || (opc == OPC_JALR);
      class_o.bf     = (opc == OPC_BF);
      class_o.bnf    = (opc == OPC_BNF);
      class_o.brcond = class_o.bf || class_o.bnf;
      class_o.branch = class_o.jbr || class_o.jr || class_o.jal;

      class_o.alu = alu_rr || (opc == OPC_ORI) || (opc == OPC_ANDI) || (opc == OPC_XORI);

      // Load/store unit
      class_o.load  = (opc >= OPC_LWZ) && (opc <= OPC_LHS);
      class_o.store = (opc == OPC_SW) || (opc == OPC_SB) || (opc == OPC_SH);
      case (fields_i.opcode)
         OPC_SB, OPC_LBZ, OPC_LBS: class_o.lsu_length = 2'b00;
         OPC_SH, OPC_LHZ, OPC_LHS: class_o.lsu_length = 2'b01;
         default:                  class_o.lsu_length = 2'b10;
      endcase
      class_o.lsu_zext = opc[0];

      class_o.mfspr   = (opc == OPC_MFSPR);
      class_o.mtspr   = (opc == OPC_MTSPR);
      class_o.rfe     = (opc == OPC_RFE);
      class_o.setflag = (opc == OPC_SF) || (opc == OPC_SFIMM);
      class_o.movhi   = (opc == OPC_MOVHI);

      // Arithmetic units
      class_o.add = (alu_rr && ((fields_i.alu_opc == ALU_ADD) ||
                                (fields_i.alu_opc == ALU_SUB))) ||
                    (opc == OPC_ADDI);
      class_o.mul_signed   = (alu_rr && (fields_i.alu_opc == ALU_MUL)) || (opc == OPC_MULI);
      class_o.mul_unsigned = alu_rr && (fields_i.alu_opc == ALU_MULU);
      class_o.shift        = (alu_rr && (fields_i.alu_opc == ALU_SHRT)) || (opc == OPC_SHRTI);

      // Writeback: link, movhi, 10xxxx except sfxxi, 11xxxx except sf, mtspr, stores
      class_o.rf_wb = class_o.jal || class_o.movhi ||
                      ((opc[5:4] == 2'b10) && (opc != OPC_SFIMM)) ||
                      ((opc[5:4] == 2'b11) && !((opc == OPC_SF) || class_o.mtspr ||
                                                class_o.store));

      // Compares run through the adder as a subtract
      class_o.adder_do_sub = (alu_rr && (fields_i.alu_opc == ALU_SUB)) || class_o.setflag;
   end

endmodule

// File: design/operand_decode.sv
`include "decode_params.svh"

module operand_decode (
   input  decode_pkg::insn_fields_t fields_i,
   input  decode_pkg::op_class_t    class_i,
   output decode_pkg::operand_t     operand_o
);
   import decode_pkg::*;

   logic [5:0]                    opc;
   logic [`DEC_OPERAND_WIDTH-1:0] imm_sext;
   logic [`DEC_OPERAND_WIDTH-1:0] imm_zext;
   logic [`DEC_OPERAND_WIDTH-1:0] imm_high;
   logic                          imm_sext_sel;
   logic                          imm_zext_sel;
   logic                          logic_imm;

   assign opc       = fields_i.opcode;
   assign logic_imm = (opc == OPC_ORI) || (opc == OPC_ANDI);

   assign imm_sext = {{(`DEC_OPERAND_WIDTH-16){fields_i.imm16[15]}}, fields_i.imm16};
   assign imm_zext = {{(`DEC_OPERAND_WIDTH-16){1'b0}}, fields_i.imm16};
   assign imm_high = {fields_i.imm16, {(`DEC_OPERAND_WIDTH-16){1'b0}}};

   // Arithmetic immediates and store offsets are signed
   assign imm_sext_sel = ((opc[5:4] == 2'b10) && !logic_imm) || class_i.store;
   assign imm_zext_sel = logic_imm || class_i.mtspr;

   always_comb begin
      operand_o.rfa          = fields_i.ra;
      operand_o.rfb          = fields_i.rb;
      operand_o.rfd          = class_i.jal ? `DEC_RF_ADDR_WIDTH'(`DEC_LINK_REG) : fields_i.rd;
      operand_o.imm16        = fields_i.imm16;
      operand_o.immjbr_upper = fields_i.jbr_upper;

      if (imm_sext_sel) begin
         operand_o.immediate = imm_sext;
      end else if (imm_zext_sel) begin
         operand_o.immediate = imm_zext;
      end else begin
         operand_o.immediate = imm_high;
      end
      operand_o.immediate_sel = imm_sext_sel || imm_zext_sel || class_i.movhi;

      // Logical immediates reuse the register-register ALU functions
      case (fields_i.opcode)
         OPC_ORI:  operand_o.opc_alu = ALU_OR;
         OPC_ANDI: operand_o.opc_alu = ALU_AND;
         OPC_XORI: operand_o.opc_alu = ALU_XOR;
         default:  operand_o.opc_alu = fields_i.alu_opc;
      endcase

      // Compare condition for setflag, shift kind otherwise
      operand_o.opc_alu_secondary = class_i.setflag ? fields_i.comp_opc :
                                                      {1'b0, fields_i.secondary};
   end

endmodule

// File: design/illegal_check.sv
`include "decode_params.svh"

module illegal_check (
   input  decode_pkg::insn_fields_t fields_i,
   output decode_pkg::except_t      except_o
);
   import decode_pkg::*;

   localparam logic [9:0] SYSOP_SYSCALL = 10'h000;
   localparam logic [9:0] SYSOP_TRAP    = 10'h100;
   localparam logic [9:0] SYSOP_MSYNC   = 10'h200;

   logic shift_bad;
   logic is_sys;

   assign is_sys = (fields_i.opcode == OPC_SYSTRAPSYNC);

   // Shared by the register and immediate shift forms
   always_comb begin
      case (fields_i.secondary)
         SHIFT_SLL, SHIFT_SRL: shift_bad = 1'b0;
         SHIFT_SRA:            shift_bad = (`DEC_HAS_SRA == 0);
         SHIFT_ROR:            shift_bad = (`DEC_HAS_ROR == 0);
         default:              shift_bad = 1'b1;
      endcase
   end

   always_comb begin
      except_o.syscall = is_sys && (fields_i.sys_subop == SYSOP_SYSCALL) &&
                         (`DEC_HAS_SYSCALL != 0);
      except_o.trap    = is_sys && (fields_i.sys_subop == SYSOP_TRAP) &&
                         (`DEC_HAS_TRAP != 0);
      except_o.msync   = is_sys && (fields_i.sys_subop == SYSOP_MSYNC) &&
                         (`DEC_HAS_MSYNC != 0);

      case (fields_i.opcode)
         OPC_J, OPC_JAL, OPC_BNF, OPC_BF, OPC_NOP, OPC_MOVHI, OPC_RFE,
         OPC_JR, OPC_JALR, OPC_LWZ, OPC_LWS, OPC_LBZ, OPC_LBS, OPC_LHZ,
         OPC_LHS, OPC_ADDI, OPC_ANDI, OPC_ORI, OPC_XORI, OPC_MFSPR,
         OPC_SFIMM, OPC_MTSPR, OPC_SW, OPC_SB, OPC_SH, OPC_SF:
            except_o.illegal = 1'b0;
         OPC_ADDIC: except_o.illegal = (`DEC_HAS_ADDC == 0);
         OPC_MULI:  except_o.illegal = (`DEC_HAS_MUL == 0);
         OPC_SHRTI: except_o.illegal = shift_bad;
         OPC_ALU: begin
            case (fields_i.alu_opc)
               ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR:
                  except_o.illegal = 1'b0;
               ALU_ADDC:           except_o.illegal = (`DEC_HAS_ADDC == 0);
               ALU_MUL, ALU_MULU:  except_o.illegal = (`DEC_HAS_MUL == 0);
               ALU_DIV, ALU_DIVU:  except_o.illegal = (`DEC_HAS_DIV == 0);
               ALU_SHRT:           except_o.illegal = shift_bad;
               // cmov, ff1/fl1, extend and unassigned codes
               default:            except_o.illegal = 1'b1;
            endcase
         end
         OPC_SYSTRAPSYNC:
            except_o.illegal = !(except_o.syscall || except_o.trap || except_o.msync);
         default: except_o.illegal = 1'b1;
      endcase
   end

endmodule

// File: design/decode_out_stage.sv
module decode_out_stage (
   input  logic                     clk,
   input  logic                     rst_i,
   input  logic                     fields_valid_i,
   input  decode_pkg::insn_fields_t fields_i,
   input  decode_pkg::op_class_t    class_i,
   input  decode_pkg::operand_t     operand_i,
   input  decode_pkg::except_t      except_i,
   output logic                     decode_valid_o,
   output decode_pkg::decode_out_t  decode_o
);
   import decode_pkg::*;

   decode_out_t merged;

   always_comb begin
      merged.opcode   = fields_i.opcode;
      merged.op_class = class_i;
      merged.operand  = operand_i;
      merged.except   = except_i;
      // An illegal instruction must not write a register or touch memory
      if (except_i.illegal) begin
         merged.op_class.rf_wb = 1'b0;
         merged.op_class.load  = 1'b0;
         merged.op_class.store = 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         decode_valid_o <= 1'b0;
         decode_o       <= '0;
      end else begin
         decode_valid_o <= fields_valid_i;
         if (fields_valid_i) begin
            decode_o <= merged;
         end
      end
   end

endmodule

// File: design/decode_top.sv
`include "decode_params.svh"

module decode_top (
   input  logic                         clk,
   input  logic                         rst_i,
   input  logic                         insn_valid_i,
   input  logic [`DEC_INSN_WIDTH-1:0]   insn_i,
   output logic                         decode_valid_o,
   output decode_pkg::decode_out_t      decode_o
);
   import decode_pkg::*;

   insn_fields_t fields;
   logic         fields_valid;
   op_class_t    op_class;
   operand_t     operand;
   except_t      exc;

   // Stage 1, capture and field split
   insn_capture i_insn_capture (
      .clk            (clk),
      .rst_i          (rst_i),
      .insn_valid_i   (insn_valid_i),
      .insn_i         (insn_i),
      .fields_o       (fields),
      .fields_valid_o (fields_valid)
   );

   op_class_decode i_op_class_decode (
      .fields_i (fields),
      .class_o  (op_class)
   );

   operand_decode i_operand_decode (
      .fields_i  (fields),
      .class_i   (op_class),
      .operand_o (operand)
   );

   illegal_check i_illegal_check (
      .fields_i (fields),
      .except_o (exc)
   );

   // Stage 2, merged record register
   decode_out_stage i_decode_out_stage (
      .clk            (clk),
      .rst_i          (rst_i),
      .fields_valid_i (fields_valid),
      .fields_i       (fields),
      .class_i        (op_class),
      .operand_i      (operand),
      .except_i       (exc),
      .decode_valid_o (decode_valid_o),
      .decode_o       (decode_o)
   );

endmodule

// File: testbench/tb_decode_top.sv
`include "decode_params.svh"

module tb_decode_top;
   timeunit 1ns;
   timeprecision 1ps;

   import decode_pkg::*;

   localparam int          RESET_CYCLES = 5;
   localparam int          N_OPC        = 35;
   localparam int          N_DIRECTED   = N_OPC + 64 + 4 + 6;
   localparam int          N_RANDOM     = 400;
   localparam int          CYCLE_LIMIT  = RESET_CYCLES + N_DIRECTED + N_RANDOM + 20;
   localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;

   // Every listed major opcode, then FPU, two custom slots and one unassigned code
   localparam logic [5:0] OPC_LIST [0:N_OPC-1] = '{
      6'h00, 6'h01, 6'h03, 6'h04, 6'h05, 6'h06, 6'h08, 6'h09, 6'h11, 6'h12,
      6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h28, 6'h29, 6'h2A,
      6'h2B, 6'h2C, 6'h2D, 6'h2E, 6'h2F, 6'h30, 6'h35, 6'h36, 6'h37, 6'h38,
      6'h39, 6'h32, 6'h1C, 6'h3C, 6'h0A
   };
   localparam logic [9:0] SYS_LIST [0:5] = '{
      10'h000, 10'h100, 10'h200, 10'h300, 10'h001, 10'h0FF
   };

   logic                       clk;
   logic                       rst_i;
   logic                       insn_valid_i;
   logic [`DEC_INSN_WIDTH-1:0] insn_i;
   logic                       decode_valid_o;
   decode_out_t                decode_o;

   logic [31:0] lfsr_state = 32'h43a;
   int          value_errors = 0;
   int          other_errors = 0;
   int          cycle_count = 0;
   logic [1:0]  valid_hist;
   decode_out_t expected_q[$];
   logic [31:0] word_q[$];
   decode_out_t expected;
   logic [31:0] word;
   logic [31:0] stim_word;

   decode_top i_decode_top (
      .clk            (clk),
      .rst_i          (rst_i),
      .insn_valid_i   (insn_valid_i),
      .insn_i         (insn_i),
      .decode_valid_o (decode_valid_o),
      .decode_o       (decode_o)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Galois LFSR, one step per bit handed out
   function automatic logic [31:0] lfsr_take(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_state[0]};
         lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
      end
      return v;
   endfunction

   // Expected record from the instruction word
   function automatic decode_out_t model_decode(input logic [31:0] w);
      decode_out_t r;
      logic [5:0]  op;
      logic [3:0]  fn;
      logic [3:0]  sec;
      logic [9:0]  sub;
      logic [15:0] imm;
      logic        rr;
      logic        sext;
      logic        zext;
      logic        shift_ok;
      op  = w[31:26];
      fn  = w[3:0];
      sec = w[9:6];
      sub = w[25:16];
      rr  = (op == 6'h38);
      r   = '0;
      r.opcode = opcode_e'(op);

      r.op_class.jbr     = (op < 6'h05);
      r.op_class.jr      = (op == 6'h11) || (op == 6'h12);
      r.op_class.jal     = (op == 6'h01) || (op == 6'h12);
      r.op_class.bf      = (op == 6'h04);
      r.op_class.bnf     = (op == 6'h03);
      r.op_class.brcond  = (op == 6'h04) || (op == 6'h03);
      r.op_class.branch  = r.op_class.jbr || r.op_class.jr || r.op_class.jal;
      r.op_class.alu     = rr || (op == 6'h29) || (op == 6'h2A) || (op == 6'h2B);
      r.op_class.load    = (op >= 6'h21) && (op <= 6'h26);
      r.op_class.store   = (op >= 6'h35) && (op <= 6'h37);
      case (op)
         6'h36, 6'h23, 6'h24: r.op_class.lsu_length = 2'b00;
         6'h37, 6'h25, 6'h26: r.op_class.lsu_length = 2'b01;
         default:             r.op_class.lsu_length = 2'b10;
      endcase
      r.op_class.lsu_zext     = op[0];
      r.op_class.mfspr        = (op == 6'h2D);
      r.op_class.mtspr        = (op == 6'h30);
      r.op_class.rfe          = (op == 6'h09);
      r.op_class.setflag      = (op == 6'h39) || (op == 6'h2F);
      r.op_class.movhi        = (op == 6'h06);
      r.op_class.add          = (rr && ((fn == 4'h0) || (fn == 4'h2))) || (op == 6'h27);
      r.op_class.mul_signed   = (rr && (fn == 4'h6)) || (op == 6'h2C);
      r.op_class.mul_unsigned = rr && (fn == 4'hB);
      r.op_class.shift        = (rr && (fn == 4'h8)) || (op == 6'h2E);
      r.op_class.rf_wb = r.op_class.jal || r.op_class.movhi ||
                         ((op[5:4] == 2'b10) && (op != 6'h2F)) ||
                         ((op[5:4] == 2'b11) && (op != 6'h39) && (op != 6'h30) &&
                          !r.op_class.store);
      r.op_class.adder_do_sub = (rr && (fn == 4'h2)) || r.op_class.setflag;

      // Stores and mtspr split the immediate around rb
      imm = (r.op_class.store || (op == 6'h30)) ? {w[25:21], w[10:0]} : w[15:0];
      sext = ((op[5:4] == 2'b10) && (op != 6'h2A) && (op != 6'h29)) || r.op_class.store;
      zext = (op == 6'h2A) || (op == 6'h29) || (op == 6'h30);
      r.operand.rfa          = w[20:16];
      r.operand.rfb          = w[15:11];
      r.operand.rfd          = r.op_class.jal ? 5'(`DEC_LINK_REG) : w[25:21];
      r.operand.imm16        = imm;
      r.operand.immjbr_upper = w[25:16];
      if (sext) begin
         r.operand.immediate = {{16{imm[15]}}, imm};
      end else if (zext) begin
         r.operand.immediate = {16'h0000, imm};
      end else begin
         r.operand.immediate = {imm, 16'h0000};
      end
      r.operand.immediate_sel = sext || zext || r.op_class.movhi;
      case (op)
         6'h2A:   r.operand.opc_alu = alu_opc_e'(4'h4);
         6'h29:   r.operand.opc_alu = alu_opc_e'(4'h3);
         6'h2B:   r.operand.opc_alu = alu_opc_e'(4'h5);
         default: r.operand.opc_alu = alu_opc_e'(fn);
      endcase
      r.operand.opc_alu_secondary = r.op_class.setflag ? w[25:21] : {1'b0, sec};

      r.except.syscall = (op == 6'h08) && (sub == 10'h000);
      r.except.trap    = (op == 6'h08) && (sub == 10'h100);
      r.except.msync   = (op == 6'h08) && (sub == 10'h200);
      shift_ok = (sec == 4'h0) || (sec == 4'h1) || ((sec == 4'h2) && (`DEC_HAS_SRA != 0)) ||
                 ((sec == 4'h3) && (`DEC_HAS_ROR != 0));
      case (op)
         6'h00, 6'h01, 6'h03, 6'h04, 6'h05, 6'h06, 6'h09, 6'h11, 6'h12, 6'h21,
         6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h29, 6'h2A, 6'h2B, 6'h2D,
         6'h2F, 6'h30, 6'h35, 6'h36, 6'h37, 6'h39:
            r.except.illegal = 1'b0;
         6'h28: r.except.illegal = (`DEC_HAS_ADDC == 0);
         6'h2C: r.except.illegal = (`DEC_HAS_MUL == 0);
         6'h2E: r.except.illegal = !shift_ok;
         6'h38: begin
            case (fn)
               4'h0, 4'h2, 4'h3, 4'h4, 4'h5: r.except.illegal = 1'b0;
               4'h6, 4'hB:                   r.except.illegal = (`DEC_HAS_MUL == 0);
               4'h9, 4'hA:                   r.except.illegal = (`DEC_HAS_DIV == 0);
               4'h1:                         r.except.illegal = (`DEC_HAS_ADDC == 0);
               4'h8:                         r.except.illegal = !shift_ok;
               default:                      r.except.illegal = 1'b1;
            endcase
         end
         6'h08:   r.except.illegal = !(r.except.syscall || r.except.trap || r.except.msync);
         default: r.except.illegal = 1'b1;
      endcase
      if (r.except.illegal) begin
         r.op_class.rf_wb = 1'b0;
         r.op_class.load  = 1'b0;
         r.op_class.store = 1'b0;
      end
      return r;
   endfunction

   task automatic flag_mismatch(input string what);
      value_errors++;
      $display("error %0t: %s", $time, what);
   endtask

   task automatic issue(input logic [31:0] w);
      insn_valid_i <= 1'b1;
      insn_i       <= w;
      @(posedge clk);
   endtask

   task automatic idle(input logic [31:0] w);
      insn_valid_i <= 1'b0;
      insn_i       <= w;
      @(posedge clk);
   endtask

   // Response checks against the head of the expected queue
   always @(posedge clk) begin
      if (rst_i) begin
         valid_hist = 2'b00;
      end else begin
         assert (decode_valid_o === valid_hist[1])
            else flag_mismatch("decode_valid_o not two cycles after the strobe");
         if (decode_valid_o === 1'b1) begin
            if (expected_q.size() == 0) begin
               other_errors++;
               $display("Output valid was raised with no instruction outstanding");
            end else begin
               expected = expected_q.pop_front();
               word     = word_q.pop_front();
               assert (decode_o === expected) else flag_mismatch("decode record differs");
               assert (decode_o.op_class === expected.op_class)
                  else flag_mismatch("class flags, lsu attributes or rf_wb differ");
               if (expected.op_class.jal) begin
                  assert (decode_o.operand.rfd == `DEC_LINK_REG)
                     else flag_mismatch("jump-and-link rfd is not the link register");
               end
               assert ((decode_o.operand.immediate === expected.operand.immediate) &&
                       (decode_o.operand.immediate_sel === expected.operand.immediate_sel))
                  else flag_mismatch("immediate or immediate select differs");
               if ((word[31:26] >= 6'h35) && (word[31:26] <= 6'h37)) begin
                  assert (decode_o.operand.imm16 === {word[25:21], word[10:0]})
                     else flag_mismatch("store imm16 not reassembled");
               end
               if ((word[31:26] >= 6'h29) && (word[31:26] <= 6'h2B)) begin
                  assert (decode_o.operand.opc_alu === expected.operand.opc_alu)
                     else flag_mismatch("logical immediate ALU opcode not remapped");
               end
               assert (decode_o.operand.opc_alu_secondary ===
                       expected.operand.opc_alu_secondary)
                  else flag_mismatch("secondary opcode differs");
               assert (decode_o.except === expected.except)
                  else flag_mismatch("illegal, syscall, trap or msync flag differs");
               if (expected.except.illegal) begin
                  assert (!decode_o.op_class.rf_wb && !decode_o.op_class.load &&
                          !decode_o.op_class.store)
                     else flag_mismatch("illegal instruction keeps a side effect");
               end
            end
         end
         if (insn_valid_i === 1'b1) begin
            expected_q.push_back(model_decode(insn_i));
            word_q.push_back(insn_i);
         end
         valid_hist = {valid_hist[0], insn_valid_i};
      end
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("Timeout after %0d cycles, the stimulus did not finish", cycle_count);
         $display("Simulation failed");
         $finish;
      end
   end

   initial begin
      rst_i        = 1'b1;
      insn_valid_i = 1'b0;
      insn_i       = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      assert ((decode_valid_o === 1'b0) && (decode_o === '0))
         else flag_mismatch("outputs not cleared by reset");
      rst_i <= 1'b0;

      // Directed, back to back
      for (int i = 0; i < N_OPC; i++) begin
         issue({OPC_LIST[i], 26'(lfsr_take(26))});
      end
      for (int s = 0; s < 4; s++) begin
         for (int f = 0; f < 16; f++) begin
            issue({6'h38, 16'(lfsr_take(16)), 4'(s), 2'(lfsr_take(2)), 4'(f)});
         end
      end
      for (int s = 0; s < 4; s++) begin
         issue({6'h2E, 16'(lfsr_take(16)), 4'(s), 6'(lfsr_take(6))});
      end
      for (int i = 0; i < 6; i++) begin
         issue({6'h08, SYS_LIST[i], 16'(lfsr_take(16))});
      end

      // Random words with gaps, opcodes mostly from the table
      for (int i = 0; i < N_RANDOM; i++) begin
         stim_word = lfsr_take(32);
         if (lfsr_take(1) != 0) begin
            stim_word[31:26] = OPC_LIST[lfsr_take(6) % N_OPC];
         end
         if (lfsr_take(2) != 0) begin
            issue(stim_word);
         end else begin
            idle(stim_word);
         end
      end
      idle(32'h0);
      repeat (3) @(posedge clk);

      if (expected_q.size() != 0) begin
         other_errors++;
         $display("%0d instructions never came out of the decode stage", expected_q.size());
      end
      $display("Value errors: %0d, other failures: %0d", value_errors, other_errors);
      if ((value_errors == 0) && (other_errors == 0)) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// File: all.f
+incdir+include
design/decode_pkg.sv
design/insn_capture.sv
design/op_class_decode.sv
design/operand_decode.sv
design/illegal_check.sv
design/decode_out_stage.sv
design/decode_top.sv
testbench/tb_decode_top.sv

// File: Bender.yml
package:
  name: decode_stage

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/decode_pkg.sv
      - design/insn_capture.sv
      - design/op_class_decode.sv
      - design/operand_decode.sv
      - design/illegal_check.sv
      - design/decode_out_stage.sv
      - design/decode_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_decode_top.sv
